/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // RISC-V load/store width codes, stores use B, H and W
    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_BU = 3'b100,
        F3_HU = 3'b101
    } mem_funct3_e;

    // One memory word, seen whole or as its lanes
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;  // half[0] is bits 15:0
        logic [3:0][7:0]  bytes; // bytes[0] is bits 7:0
    } mem_word_u;

    // Byte enables and lane-shifted data for a store
    function automatic void store_lanes(
        input  mem_funct3_e funct3,
        input  logic [1:0]  offset,
        input  logic [31:0] data,
        output logic [3:0]  be,
        output mem_word_u   lanes
    );
        lanes.word = '0;
        be         = 4'b0000;
        case (funct3)
            F3_B, F3_BU: begin
                lanes.bytes[offset] = data[7:0];
                be[offset]          = 1'b1;
            end
            F3_H, F3_HU: begin
                lanes.half[offset[1]] = data[15:0];
                be = offset[1] ? 4'b1100 : 4'b0011;
            end
            F3_W: begin
                lanes.word = data;
                be         = 4'b1111;
            end
            default: be = 4'b0000; // Unsupported code writes nothing
        endcase
    endfunction

    // Selected lane of a loaded word, sign or zero extended
    function automatic logic [31:0] load_extract(
        input mem_funct3_e funct3,
        input logic [1:0]  offset,
        input mem_word_u   w
    );
        logic [7:0]  lane_b;
        logic [15:0] lane_h;
        lane_b = w.bytes[offset];
        lane_h = w.half[offset[1]];
        case (funct3)
            F3_B:    return {{24{lane_b[7]}}, lane_b};
            F3_BU:   return {24'd0, lane_b};
            F3_H:    return {{16{lane_h[15]}}, lane_h};
            F3_HU:   return {16'd0, lane_h};
            F3_W:    return w.word;
            default: return 32'd0;
        endcase
    endfunction

    // Same width rules as store_lanes, plus natural alignment
    function automatic logic access_ok(
        input mem_funct3_e funct3,
        input logic [1:0]  offset
    );
        case (funct3)
            F3_B, F3_BU: return 1'b1;
            F3_H, F3_HU: return ~offset[0];
            F3_W:        return offset == 2'b00;
            default:     return 1'b0; // funct3 3, 6 and 7
        endcase
    endfunction

endpackage

`default_nettype wire

/* hw/mem_port_if.sv */
`timescale 1ns/100ps
`default_nettype none

// One byte-enabled synchronous RAM port
interface mem_port_if #(
    parameter int AW = 11
);

    logic          en;
    logic          we;    // Write when high, read when low
    logic [3:0]    be;
    logic [AW-1:0] addr;  // Word address
    logic [31:0]   wdata;
    logic [31:0]   rdata; // Held until the next read

    modport master (
        output en, we, be, addr, wdata,
        input  rdata
    );

    modport ram (
        input  en, we, be, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* hw/dual_port_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module dual_port_ram #(
    parameter int MEM_WORDS = 2048
) (
    input  logic                         clk,
    mem_port_if.ram                      a,
    input  logic                         b_we,
    input  logic [$clog2(MEM_WORDS)-1:0] b_addr,
    input  logic [31:0]                  b_wdata
);

    logic [31:0] mem [MEM_WORDS];

    // Port a does byte writes or a registered read, port b whole-word writes
    always_ff @(posedge clk) begin
        if (a.en) begin
            if (a.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (a.be[i]) begin
                        mem[a.addr][i*8 +: 8] <= a.wdata[i*8 +: 8];
                    end
                end
            end else begin
                a.rdata <= mem[a.addr]; // Read data stays until next read
            end
        end
        if (b_we) begin
            mem[b_addr] <= b_wdata; // Fill and restore path
        end
    end

endmodule

`default_nettype wire

/* hw/lsu_access_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_access_unit #(
    parameter int MEM_WORDS = 2048
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  logic                 issue_ready,
    input  logic                 issue_is_store,
    input  lsu_pkg::mem_funct3_e issue_funct3,
    input  logic [31:0]          issue_addr,
    input  logic [31:0]          issue_data,
    input  logic [31:0]          issue_inst_num,
    input  logic [7:0]           issue_phy,
    input  logic                 exception_sig,
    mem_port_if.master           spec,
    output logic                 result_valid,
    output logic                 result_is_store,
    output logic                 result_fault,
    output logic [31:0]          result_data,
    output logic [31:0]          result_inst_num,
    output logic [31:0]          result_addr,
    output logic [7:0]           result_phy
);

    import lsu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    // Stage 1, accepted op driving the RAM
    logic        s1_valid;
    logic        s1_is_store;
    mem_funct3_e s1_funct3;
    logic [31:0] s1_addr;
    logic [31:0] s1_data;
    logic [31:0] s1_inst_num;
    logic [7:0]  s1_phy;
    logic        s1_ok;
    logic [3:0]  s1_be;
    mem_word_u   s1_lanes;

    // Stage 2, tags waiting on rdata
    logic        s2_valid;
    logic        s2_is_store;
    logic        s2_fault;
    mem_funct3_e s2_funct3;
    logic [31:0] s2_addr;
    logic [31:0] s2_inst_num;
    logic [7:0]  s2_phy;
    logic [31:0] s2_value;

    always_comb begin
        s1_ok = (s1_addr[31:AW+2] == '0) && access_ok(s1_funct3, s1_addr[1:0]);
        store_lanes(s1_funct3, s1_addr[1:0], s1_data, s1_be, s1_lanes);
        spec.en    = s1_valid & s1_ok & ~exception_sig; // Faulty or squashed op stays off
        spec.we    = s1_is_store;
        spec.be    = s1_be;
        spec.addr  = s1_addr[AW+1:2];
        spec.wdata = s1_lanes.word;
    end

    always_comb begin
        if (s2_is_store || s2_fault) begin
            s2_value = 32'd0;
        end else begin
            s2_value = load_extract(s2_funct3, s2_addr[1:0], spec.rdata);
        end
    end

    // Valid chain, an exception drops everything in flight
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= issue_valid & issue_ready & ~exception_sig;
            s2_valid     <= s1_valid & ~exception_sig;
            result_valid <= s2_valid & ~exception_sig;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            s1_is_store <= issue_is_store;
            s1_funct3   <= issue_funct3;
            s1_addr     <= issue_addr;
            s1_data     <= issue_data;
            s1_inst_num <= issue_inst_num;
            s1_phy      <= issue_phy;
        end
        s2_is_store     <= s1_is_store;
        s2_fault        <= ~s1_ok;
        s2_funct3       <= s1_funct3;
        s2_addr         <= s1_addr;
        s2_inst_num     <= s1_inst_num;
        s2_phy          <= s1_phy;
        result_is_store <= s2_is_store;
        result_fault    <= s2_fault;
        result_data     <= s2_value;
        result_inst_num <= s2_inst_num;
        result_addr     <= s2_addr; // Byte address, stores report it
        result_phy      <= s2_phy;
    end

endmodule

`default_nettype wire

/* hw/rollback_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module rollback_unit #(
    parameter int MEM_WORDS = 2048
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         exception_sig,
    input  logic                         commit_valid,
    input  lsu_pkg::mem_funct3_e         commit_funct3,
    input  logic [31:0]                  commit_addr,
    input  logic [31:0]                  commit_data,
    output logic                         ready,
    mem_port_if.master                   committed,
    output logic                         spec_we,
    output logic [$clog2(MEM_WORDS)-1:0] spec_waddr,
    output logic [31:0]                  spec_wdata,
    output logic                         fill_we,
    output logic [$clog2(MEM_WORDS)-1:0] fill_waddr,
    output logic [31:0]                  fill_wdata
);

    import lsu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    localparam logic [1:0] ST_FILL    = 2'd0;
    localparam logic [1:0] ST_IDLE    = 2'd1;
    localparam logic [1:0] ST_RESTORE = 2'd2;

    logic [1:0]  state;
    logic [AW:0] cnt;      // Extra bit marks the restore tail cycle
    logic [AW:0] cnt_prev;
    logic        commit_in_range;
    logic [3:0]  commit_be;
    mem_word_u   commit_lanes;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FILL;
            cnt   <= '0;
        end else begin
            case (state)
                ST_FILL: begin
                    cnt <= cnt + 1'b1;
                    if (&cnt[AW-1:0]) begin // Last word written
                        state <= ST_IDLE;
                        cnt   <= '0;
                    end
                end
                ST_IDLE: begin
                    if (exception_sig) begin
                        state <= ST_RESTORE;
                        cnt   <= '0;
                    end
                end
                ST_RESTORE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt[AW]) begin // Final write of word MEM_WORDS-1
                        state <= ST_IDLE;
                        cnt   <= '0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        cnt_prev        = cnt - 1'b1;
        commit_in_range = (commit_addr[31:AW+2] == '0);
        store_lanes(commit_funct3, commit_addr[1:0], commit_data, commit_be, commit_lanes);
        ready           = (state == ST_IDLE);

        committed.en    = 1'b0;
        committed.we    = 1'b0;
        committed.be    = 4'b0000;
        committed.addr  = cnt[AW-1:0];
        committed.wdata = commit_lanes.word;
        spec_we         = 1'b0;
        spec_waddr      = cnt[AW-1:0];
        spec_wdata      = 32'(cnt[AW-1:0]); // Fill value is the word index
        case (state)
            ST_FILL: spec_we = 1'b1;
            ST_IDLE: begin
                committed.en   = commit_valid & commit_in_range;
                committed.we   = 1'b1;
                committed.be   = commit_be;
                committed.addr = commit_addr[AW+1:2];
            end
            ST_RESTORE: begin
                committed.en = ~cnt[AW];        // Read word cnt
                spec_we      = (cnt != '0);     // Write word read last cycle
                spec_waddr   = cnt_prev[AW-1:0];
                spec_wdata   = committed.rdata;
            end
            default: spec_we = 1'b0;
        endcase
    end

    // Committed RAM port b only serves the reset fill
    assign fill_we    = (state == ST_FILL);
    assign fill_waddr = cnt[AW-1:0];
    assign fill_wdata = 32'(cnt[AW-1:0]);

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
    parameter int MEM_WORDS = 2048
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 issue_valid,
    input  logic                 issue_is_store,
    input  lsu_pkg::mem_funct3_e issue_funct3,
    input  logic [31:0]          issue_addr,
    input  logic [31:0]          issue_data,
    input  logic [31:0]          issue_inst_num,
    input  logic [7:0]           issue_phy,
    output logic                 issue_ready,

    input  logic                 commit_valid,
    input  lsu_pkg::mem_funct3_e commit_funct3,
    input  logic [31:0]          commit_addr,
    input  logic [31:0]          commit_data,
    output logic                 commit_ready,

    input  logic                 exception_sig,

    output logic                 result_valid,
    output logic                 result_is_store,
    output logic                 result_fault,
    output logic [31:0]          result_data,
    output logic [31:0]          result_inst_num,
    output logic [31:0]          result_addr,
    output logic [7:0]           result_phy
);

    localparam int AW = $clog2(MEM_WORDS);

    logic          ready;
    logic          spec_b_we;
    logic [AW-1:0] spec_b_addr;
    logic [31:0]   spec_b_wdata;
    logic          fill_we;
    logic [AW-1:0] fill_waddr;
    logic [31:0]   fill_wdata;

    mem_port_if #(.AW(AW)) spec_if ();   // Access unit to speculative RAM
    mem_port_if #(.AW(AW)) commit_if (); // Rollback unit to committed RAM

    assign issue_ready  = ready; // Both ports stall during fill and restore
    assign commit_ready = ready;

    lsu_access_unit #(
        .MEM_WORDS (MEM_WORDS)
    ) access0 (
        .clk             (clk),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue_ready     (ready),
        .issue_is_store  (issue_is_store),
        .issue_funct3    (issue_funct3),
        .issue_addr      (issue_addr),
        .issue_data      (issue_data),
        .issue_inst_num  (issue_inst_num),
        .issue_phy       (issue_phy),
        .exception_sig   (exception_sig),
        .spec            (spec_if),
        .result_valid    (result_valid),
        .result_is_store (result_is_store),
        .result_fault    (result_fault),
        .result_data     (result_data),
        .result_inst_num (result_inst_num),
        .result_addr     (result_addr),
        .result_phy      (result_phy)
    );

    rollback_unit #(
        .MEM_WORDS (MEM_WORDS)
    ) rollback0 (
        .clk           (clk),
        .reset         (reset),
        .exception_sig (exception_sig),
        .commit_valid  (commit_valid),
        .commit_funct3 (commit_funct3),
        .commit_addr   (commit_addr),
        .commit_data   (commit_data),
        .ready         (ready),
        .committed     (commit_if),
        .spec_we       (spec_b_we),
        .spec_waddr    (spec_b_addr),
        .spec_wdata    (spec_b_wdata),
        .fill_we       (fill_we),
        .fill_waddr    (fill_waddr),
        .fill_wdata    (fill_wdata)
    );

    dual_port_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) spec_ram0 (
        .clk     (clk),
        .a       (spec_if),
        .b_we    (spec_b_we),
        .b_addr  (spec_b_addr),
        .b_wdata (spec_b_wdata)
    );

    dual_port_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) commit_ram0 (
        .clk     (clk),
        .a       (commit_if),
        .b_we    (fill_we),
        .b_addr  (fill_waddr),
        .b_wdata (fill_wdata)
    );

endmodule

`default_nettype wire

/* dv/lsu_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0; // Released on a falling edge like all stimulus
    end

endmodule

`default_nettype wire

/* dv/lsu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;

    import lsu_pkg::*;

    localparam int MEM_WORDS    = 64;
    localparam int RESET_CYCLES = 16;

    localparam logic [1:0] K_ISSUE  = 2'd0;
    localparam logic [1:0] K_COMMIT = 2'd1;
    localparam logic [1:0] K_EXC    = 2'd2; // Commit rides along when is_store is set
    localparam logic [1:0] K_WAIT   = 2'd3; // exp_data holds the expected stall length

    typedef struct packed {
        logic [1:0]  kind;
        logic        is_store;
        logic [2:0]  f3;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] inst_num;
        logic [7:0]  phy;
        logic [31:0] exp_data;
        logic        exp_fault;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        issue_valid;
    logic        issue_is_store;
    mem_funct3_e issue_funct3;
    logic [31:0] issue_addr;
    logic [31:0] issue_data;
    logic [31:0] issue_inst_num;
    logic [7:0]  issue_phy;
    logic        issue_ready;
    logic        commit_valid;
    mem_funct3_e commit_funct3;
    logic [31:0] commit_addr;
    logic [31:0] commit_data;
    logic        commit_ready;
    logic        exception_sig;
    logic        result_valid;
    logic        result_is_store;
    logic        result_fault;
    logic [31:0] result_data;
    logic [31:0] result_inst_num;
    logic [31:0] result_addr;
    logic [7:0]  result_phy;

    entry_t entries[$];
    string  names[$];
    int     pipe [4];  // Entry index per cycle in flight, -2 marks a squashed op
    int     mismatches = 0;
    int     failures = 0;

    lsu_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) clock0 (.clk(clk), .reset(reset));

    lsu_top #(
        .MEM_WORDS (MEM_WORDS)
    ) dut0 (
        .clk             (clk),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue_is_store  (issue_is_store),
        .issue_funct3    (issue_funct3),
        .issue_addr      (issue_addr),
        .issue_data      (issue_data),
        .issue_inst_num  (issue_inst_num),
        .issue_phy       (issue_phy),
        .issue_ready     (issue_ready),
        .commit_valid    (commit_valid),
        .commit_funct3   (commit_funct3),
        .commit_addr     (commit_addr),
        .commit_data     (commit_data),
        .commit_ready    (commit_ready),
        .exception_sig   (exception_sig),
        .result_valid    (result_valid),
        .result_is_store (result_is_store),
        .result_fault    (result_fault),
        .result_data     (result_data),
        .result_inst_num (result_inst_num),
        .result_addr     (result_addr),
        .result_phy      (result_phy)
    );

    // Lane of a word as RISC-V loads define it
    function automatic logic [31:0] expected_lane(
        input logic [2:0]  f3,
        input logic [1:0]  off,
        input logic [31:0] word
    );
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (f3)
            3'b000:  return {{24{sh[7]}}, sh[7:0]};
            3'b100:  return {24'd0, sh[7:0]};
            3'b001:  return {{16{sh[15]}}, sh[15:0]};
            3'b101:  return {16'd0, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    task automatic push_entry(
        input logic [1:0]  kind,
        input logic        is_store,
        input logic [2:0]  f3,
        input logic [31:0] addr,
        input logic [31:0] data,
        input logic [31:0] exp_data,
        input logic        exp_fault,
        input string       name
    );
        entry_t e;
        e.kind      = kind;
        e.is_store  = is_store;
        e.f3        = f3;
        e.addr      = addr;
        e.data      = data;
        e.inst_num  = 32'h100 + entries.size(); // Unique tags per entry
        e.phy       = 8'(entries.size() * 3 + 1);
        e.exp_data  = exp_data;
        e.exp_fault = exp_fault;
        entries.push_back(e);
        names.push_back(name);
    endtask

    task automatic load_op(input logic [2:0] f3, input logic [31:0] addr,
                           input logic [31:0] exp, input string name);
        push_entry(K_ISSUE, 1'b0, f3, addr, 32'd0, exp, 1'b0, name);
    endtask

    task automatic store_op(input logic [2:0] f3, input logic [31:0] addr,
                            input logic [31:0] data, input string name);
        push_entry(K_ISSUE, 1'b1, f3, addr, data, 32'd0, 1'b0, name);
    endtask

    task automatic faulty_op(input logic is_store, input logic [2:0] f3,
                             input logic [31:0] addr, input string name);
        push_entry(K_ISSUE, is_store, f3, addr, 32'hffff_ffff, 32'd0, 1'b1, name);
    endtask

    // All five load widths at every lane of one word
    task automatic lane_sweep(input int word, input logic [31:0] model);
        mem_funct3_e codes [5];
        int          step;
        codes = '{F3_B, F3_BU, F3_H, F3_HU, F3_W};
        for (int c = 0; c < 5; c++) begin
            step = (codes[c] == F3_W) ? 4 : (codes[c] == F3_H || codes[c] == F3_HU) ? 2 : 1;
            for (int off = 0; off < 4; off += step) begin
                load_op(codes[c], 32'(word * 4 + off), expected_lane(codes[c], 2'(off), model),
                        $sformatf("sweep w%0d f3=%0d off=%0d", word, codes[c], off));
            end
        end
    endtask

    task automatic build_table();
        push_entry(K_WAIT, 1'b0, 3'd0, 32'd0, 32'd0, RESET_CYCLES + MEM_WORDS - 1, 1'b0,
                   "reset fill"); // Counting starts after the first reset edge
        load_op(F3_W, 32'h00, 32'd0, "fill w0");
        load_op(F3_W, 32'h04, 32'd1, "fill w1");
        load_op(F3_W, 32'h40, 32'd16, "fill w16");
        load_op(F3_W, 32'hfc, 32'd63, "fill w63");
        store_op(F3_B, 32'h21, 32'h1234_56a5, "sb w8");
        lane_sweep(8, 32'h0000_a508);
        store_op(F3_H, 32'h2e, 32'hffff_8001, "sh w11");
        lane_sweep(11, 32'h8001_000b);
        store_op(F3_W, 32'h34, 32'hf08c_7e81, "sw w13");
        lane_sweep(13, 32'hf08c_7e81);
        faulty_op(1'b0, F3_W, 32'h100, "lw out of range");
        faulty_op(1'b1, F3_W, 32'h104, "sw out of range");
        faulty_op(1'b0, F3_H, 32'h13, "lh misaligned");
        faulty_op(1'b1, F3_W, 32'h42, "sw misaligned");
        faulty_op(1'b1, 3'd3, 32'h44, "store funct3 3");
        faulty_op(1'b0, 3'd3, 32'h44, "load funct3 3");
        load_op(F3_W, 32'h04, 32'd1, "w1 untouched");
        load_op(F3_W, 32'h40, 32'd16, "w16 untouched");
        load_op(F3_W, 32'h44, 32'd17, "w17 untouched");
        store_op(F3_W, 32'h60, 32'h1122_3344, "b2b sw w24");
        load_op(F3_W, 32'h60, 32'h1122_3344, "b2b lw w24");
        load_op(F3_BU, 32'h63, 32'h0000_0011, "b2b lbu w24");
        store_op(F3_B, 32'h61, 32'h0000_0099, "b2b sb w24");
        load_op(F3_H, 32'h60, 32'hffff_9944, "b2b lh w24");
        store_op(F3_W, 32'h50, 32'haaaa_5555, "spec sw w20");
        push_entry(K_COMMIT, 1'b1, F3_W, 32'h54, 32'h0bad_f00d, 32'd0, 1'b0, "commit w21");
        push_entry(K_COMMIT, 1'b1, F3_H, 32'h5a, 32'h0000_1234, 32'd0, 1'b0, "commit w22");
        load_op(F3_W, 32'h50, 32'haaaa_5555, "spec w20");
        load_op(F3_W, 32'h54, 32'd21, "spec w21");
        store_op(F3_W, 32'h58, 32'hffff_ffff, "squashed sw w22");
        load_op(F3_W, 32'h50, 32'haaaa_5555, "squashed lw w20");
        push_entry(K_EXC, 1'b1, F3_W, 32'h5c, 32'h5eed_0001, 32'd0, 1'b0, "exc commit w23");
        push_entry(K_WAIT, 1'b0, 3'd0, 32'd0, 32'd0, MEM_WORDS + 1, 1'b0, "restore");
        load_op(F3_W, 32'h50, 32'd20, "restored w20");
        load_op(F3_W, 32'h54, 32'h0bad_f00d, "restored w21");
        load_op(F3_W, 32'h58, 32'h1234_0016, "restored w22");
        load_op(F3_W, 32'h5c, 32'h5eed_0001, "restored w23");
        load_op(F3_W, 32'h20, 32'd8, "restored w8");
        load_op(F3_W, 32'h60, 32'd24, "restored w24");
    endtask

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s %s expected %h actual %h", name, field, exp, act);
        end
    endtask

    task automatic check_slot();
        entry_t e;
        if (pipe[3] >= 0) begin
            e = entries[pipe[3]];
            if (result_valid !== 1'b1) begin
                failures++;
                $display("result_valid missing for %s", names[pipe[3]]);
            end else begin
                compare_field(names[pipe[3]], "is_store", 32'(e.is_store), 32'(result_is_store));
                compare_field(names[pipe[3]], "fault", 32'(e.exp_fault), 32'(result_fault));
                compare_field(names[pipe[3]], "data", e.exp_data, result_data);
                compare_field(names[pipe[3]], "inst_num", e.inst_num, result_inst_num);
                compare_field(names[pipe[3]], "phy", 32'(e.phy), 32'(result_phy));
                compare_field(names[pipe[3]], "addr", e.addr, result_addr);
            end
        end else if (result_valid !== 1'b0) begin
            failures++;
            if (pipe[3] == -2) begin
                $display("result on squashed op");
            end else begin
                $display("result_valid high with no op in flight");
            end
        end
    endtask

    // One falling edge, check the slot leaving the pipeline and clear the strobes
    task automatic tick();
        @(negedge clk);
        pipe[3] = pipe[2];
        pipe[2] = pipe[1];
        pipe[1] = pipe[0];
        pipe[0] = -1;
        check_slot();
        issue_valid   = 1'b0;
        commit_valid  = 1'b0;
        exception_sig = 1'b0;
    endtask

    initial begin
        entry_t e;
        int     low;
        issue_valid    = 1'b0;
        issue_is_store = 1'b0;
        issue_funct3   = F3_W;
        issue_addr     = 32'd0;
        issue_data     = 32'd0;
        issue_inst_num = 32'd0;
        issue_phy      = 8'd0;
        commit_valid   = 1'b0;
        commit_funct3  = F3_W;
        commit_addr    = 32'd0;
        commit_data    = 32'd0;
        exception_sig  = 1'b0;
        pipe           = '{-1, -1, -1, -1};
        build_table();
        @(posedge clk); // First edge clears the result pipeline
        for (int i = 0; i < entries.size(); i++) begin
            e = entries[i];
            tick();
            case (e.kind)
                K_WAIT: begin
                    low = 0;
                    while (issue_ready !== 1'b1) begin
                        if (commit_ready !== issue_ready) begin
                            failures++;
                            $display("commit_ready differs from issue_ready during %s", names[i]);
                        end
                        low++;
                        tick();
                    end
                    compare_field(names[i], "stall cycles", e.exp_data, 32'(low));
                end
                K_ISSUE: begin
                    if (issue_ready !== 1'b1) begin
                        failures++;
                        $display("issue_ready low when issuing %s", names[i]);
                    end else begin
                        issue_valid    = 1'b1;
                        issue_is_store = e.is_store;
                        issue_funct3   = mem_funct3_e'(e.f3);
                        issue_addr     = e.addr;
                        issue_data     = e.data;
                        issue_inst_num = e.inst_num;
                        issue_phy      = e.phy;
                        pipe[0]        = i;
                    end
                end
                default: begin
                    if (commit_ready !== 1'b1) begin
                        failures++;
                        $display("commit_ready low at %s", names[i]);
                    end
                    commit_valid  = (e.kind == K_COMMIT) || e.is_store;
                    commit_funct3 = mem_funct3_e'(e.f3);
                    commit_addr   = e.addr;
                    commit_data   = e.data;
                    if (e.kind == K_EXC) begin
                        exception_sig = 1'b1;
                        pipe[1] = (pipe[1] >= 0) ? -2 : pipe[1]; // Accepted one cycle ago
                        pipe[2] = (pipe[2] >= 0) ? -2 : pipe[2]; // Accepted two cycles ago
                    end
                end
            endcase
        end
        repeat (4) tick(); // Drain the result pipeline
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        int limit;
        #1;
        limit = entries.size() * (2 * MEM_WORDS + 10);
        repeat (limit) @(posedge clk);
        $display("watchdog timeout after %0d cycles, the table did not complete", limit);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_top.f */
hw/lsu_pkg.sv
hw/mem_port_if.sv
hw/dual_port_ram.sv
hw/lsu_access_unit.sv
hw/rollback_unit.sv
hw/lsu_top.sv
dv/lsu_clock_gen.sv
dv/lsu_tb.sv
